// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rlight_top
FILELIST  ?= rlight_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: sim clean

# build, run, then scan the log; a crash or a nonzero exit also counts as failure
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/rlight_engine.sv
`timescale 1ns/1ps

module rlight_engine #(
  parameter rlight_pkg::led_t DefaultPattern = 8'h33
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  rlight_pkg::rl_mode_e mode_i,
  input  rlight_pkg::delay_t   delay_i,
  input  logic                 pat_load_i,
  input  rlight_pkg::led_t     pat_data_i,
  output rlight_pkg::led_t     led_o
);

  // ping-pong direction
  typedef enum logic {
    DIR_LEFT,
    DIR_RIGHT
  } pp_dir_e;

  localparam logic [2:0] PpLast = 3'(rlight_pkg::PP_STEPS - 1);

  rlight_pkg::led_t   led_q;
  rlight_pkg::led_t   led_d;
  rlight_pkg::delay_t cnt_q;
  rlight_pkg::delay_t cnt_d;
  pp_dir_e            dir_q;
  pp_dir_e            dir_d;
  logic [2:0]         pp_cnt_q;
  logic [2:0]         pp_cnt_d;
  logic               step;

  function automatic rlight_pkg::led_t rotate(input rlight_pkg::led_t pat,
                                              input logic left);
    rlight_pkg::led_t res;
    if (left) begin
      res = {pat[6:0], pat[7]};
    end else begin
      res = {pat[0], pat[7:1]};
    end
    return res;
  endfunction

  // --------------------------------------------------
  // step timer and shifter
  // --------------------------------------------------

  assign step = (cnt_q == '0);  // one step every delay+1 cycles

  always_comb begin
    led_d    = led_q;
    dir_d    = dir_q;
    pp_cnt_d = pp_cnt_q;
    cnt_d    = cnt_q - 1'b1;
    if (pat_load_i) begin
      led_d    = pat_data_i;
      cnt_d    = delay_i;   // restart the interval
      dir_d    = DIR_LEFT;  // ping-pong starts over
      pp_cnt_d = '0;
    end else if (step) begin
      cnt_d = delay_i;  // mode and delay sampled here
      case (mode_i)
        rlight_pkg::MODE_PING_PONG: begin
          led_d = rotate(led_q, dir_q == DIR_LEFT);
          if (pp_cnt_q == PpLast) begin
            pp_cnt_d = '0;
            dir_d    = (dir_q == DIR_LEFT) ? DIR_RIGHT : DIR_LEFT;  // turn around
          end else begin
            pp_cnt_d = pp_cnt_q + 1'b1;
          end
        end
        rlight_pkg::MODE_ROT_LEFT:  led_d = rotate(led_q, 1'b1);
        rlight_pkg::MODE_ROT_RIGHT: led_d = rotate(led_q, 1'b0);
        default: ;  // stop, timer keeps running
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      led_q    <= DefaultPattern;
      cnt_q    <= '1;  // long first interval after reset
      dir_q    <= DIR_LEFT;
      pp_cnt_q <= '0;
    end else begin
      led_q    <= led_d;
      cnt_q    <= cnt_d;
      dir_q    <= dir_d;
      pp_cnt_q <= pp_cnt_d;
    end
  end

  assign led_o = led_q;

endmodule

// File: hw/rlight_pkg.sv
package rlight_pkg;

  // --------------------------------------------------
  // pattern and timing types
  // --------------------------------------------------

  typedef logic [7:0] led_t;    // one bit per led
  typedef logic [7:0] delay_t;  // step interval count

  // running light modes, as stored in the mode register
  typedef enum logic [1:0] {
    MODE_PING_PONG = 2'd0,
    MODE_ROT_LEFT  = 2'd1,
    MODE_ROT_RIGHT = 2'd2,
    MODE_STOP      = 2'd3
  } rl_mode_e;

  // --------------------------------------------------
  // register map (byte offsets)
  // --------------------------------------------------

  localparam int unsigned REG_MODE    = 32'h0;  // mode, bits 1:0
  localparam int unsigned REG_PATTERN = 32'h4;  // write loads, read returns live leds
  localparam int unsigned REG_DELAY   = 32'h8;  // step delay, bits 7:0

  // steps per direction before ping-pong turns around
  localparam int unsigned PP_STEPS = 7;

endpackage

// File: hw/rlight_regs.sv
`timescale 1ns/1ps

module rlight_regs #(
  parameter int unsigned        RegAw        = 4,
  parameter rlight_pkg::delay_t DefaultDelay = 8'd3
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    reg_we_i,
  input  logic                    reg_re_i,
  input  logic [RegAw-1:0]        reg_addr_i,
  input  tlul_lite_pkg::tl_data_t reg_wdata_i,
  input  logic                    reg_wmask_i,
  output tlul_lite_pkg::tl_data_t reg_rdata_o,
  output logic                    reg_err_o,

  input  rlight_pkg::led_t        led_i,
  output rlight_pkg::rl_mode_e    mode_o,
  output rlight_pkg::delay_t      delay_o,
  output logic                    pat_load_o,
  output rlight_pkg::led_t        pat_data_o
);

  logic sel_mode;
  logic sel_pat;
  logic sel_delay;
  logic wr_en;

  rlight_pkg::rl_mode_e mode_q;
  rlight_pkg::delay_t   delay_q;

  assign sel_mode  = (reg_addr_i == RegAw'(rlight_pkg::REG_MODE));
  assign sel_pat   = (reg_addr_i == RegAw'(rlight_pkg::REG_PATTERN));
  assign sel_delay = (reg_addr_i == RegAw'(rlight_pkg::REG_DELAY));
  assign wr_en     = reg_we_i & reg_wmask_i;  // byte 0 must be enabled

  // --------------------------------------------------
  // writes
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q  <= rlight_pkg::MODE_PING_PONG;
      delay_q <= DefaultDelay;
    end else if (wr_en) begin
      if (sel_mode) begin
        mode_q <= rlight_pkg::rl_mode_e'(reg_wdata_i[1:0]);
      end
      if (sel_delay) begin
        delay_q <= reg_wdata_i[7:0];
      end
    end
  end

  assign pat_load_o = wr_en & sel_pat;  // engine loads at this edge
  assign pat_data_o = reg_wdata_i[7:0];
  assign mode_o     = mode_q;
  assign delay_o    = delay_q;

  // --------------------------------------------------
  // reads
  // --------------------------------------------------

  always_comb begin
    reg_rdata_o = '0;  // unmapped reads as zero
    if (reg_re_i) begin
      if (sel_mode) reg_rdata_o[1:0] = mode_q;
      if (sel_pat) reg_rdata_o[7:0] = led_i;  // live pattern
      if (sel_delay) reg_rdata_o[7:0] = delay_q;
    end
  end

  assign reg_err_o = (reg_we_i | reg_re_i) & ~(sel_mode | sel_pat | sel_delay);

endmodule

// File: hw/rlight_top.sv
`timescale 1ns/1ps

module rlight_top #(
  parameter int unsigned        RegAw          = 4,
  parameter rlight_pkg::led_t   DefaultPattern = 8'h33,
  parameter rlight_pkg::delay_t DefaultDelay   = 8'd3
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      a_valid_i,
  input  tlul_lite_pkg::tl_opcode_t a_opcode_i,
  input  tlul_lite_pkg::tl_addr_t   a_address_i,
  input  tlul_lite_pkg::tl_data_t   a_data_i,
  input  tlul_lite_pkg::tl_mask_t   a_mask_i,
  input  tlul_lite_pkg::tl_source_t a_source_i,
  output logic                      a_ready_o,

  output logic                      d_valid_o,
  input  logic                      d_ready_i,
  output tlul_lite_pkg::tl_opcode_t d_opcode_o,
  output tlul_lite_pkg::tl_data_t   d_data_o,
  output logic                      d_error_o,
  output tlul_lite_pkg::tl_source_t d_source_o,

  output rlight_pkg::led_t          led_o
);

  // --------------------------------------------------
  // internal wires
  // --------------------------------------------------

  logic                    reg_we;
  logic                    reg_re;
  logic [RegAw-1:0]        reg_addr;
  tlul_lite_pkg::tl_data_t reg_wdata;
  logic                    reg_wmask;
  tlul_lite_pkg::tl_data_t reg_rdata;
  logic                    reg_err;

  rlight_pkg::rl_mode_e    mode;
  rlight_pkg::delay_t      delay;
  logic                    pat_load;
  rlight_pkg::led_t        pat_data;
  rlight_pkg::led_t        led;

  tlul_reg_adapter #(
    .RegAw(RegAw)
  ) u_adapter (
    .clk_i,
    .rst_ni,
    .a_valid_i,
    .a_opcode_i,
    .a_address_i,
    .a_data_i,
    .a_mask_i,
    .a_source_i,
    .a_ready_o,
    .d_valid_o,
    .d_ready_i,
    .d_opcode_o,
    .d_data_o,
    .d_error_o,
    .d_source_o,
    .reg_we_o   (reg_we),
    .reg_re_o   (reg_re),
    .reg_addr_o (reg_addr),
    .reg_wdata_o(reg_wdata),
    .reg_wmask_o(reg_wmask),
    .reg_rdata_i(reg_rdata),
    .reg_err_i  (reg_err)
  );

  rlight_regs #(
    .RegAw       (RegAw),
    .DefaultDelay(DefaultDelay)
  ) u_regs (
    .clk_i,
    .rst_ni,
    .reg_we_i   (reg_we),
    .reg_re_i   (reg_re),
    .reg_addr_i (reg_addr),
    .reg_wdata_i(reg_wdata),
    .reg_wmask_i(reg_wmask),
    .reg_rdata_o(reg_rdata),
    .reg_err_o  (reg_err),
    .led_i      (led),
    .mode_o     (mode),
    .delay_o    (delay),
    .pat_load_o (pat_load),
    .pat_data_o (pat_data)
  );

  rlight_engine #(
    .DefaultPattern(DefaultPattern)
  ) u_engine (
    .clk_i,
    .rst_ni,
    .mode_i    (mode),
    .delay_i   (delay),
    .pat_load_i(pat_load),
    .pat_data_i(pat_data),
    .led_o     (led)
  );

  assign led_o = led;

endmodule

// File: hw/tlul_lite_pkg.sv
package tlul_lite_pkg;

  // --------------------------------------------------
  // bus field widths
  // --------------------------------------------------

  typedef logic [31:0] tl_addr_t;    // byte address
  typedef logic [31:0] tl_data_t;    // data word
  typedef logic [3:0]  tl_mask_t;    // one bit per byte lane
  typedef logic [7:0]  tl_source_t;  // requester id
  typedef logic [2:0]  tl_opcode_t;  // a and d channel opcode

  // channel a opcodes
  localparam tl_opcode_t OP_PUT_FULL    = 3'd0;
  localparam tl_opcode_t OP_PUT_PARTIAL = 3'd1;
  localparam tl_opcode_t OP_GET         = 3'd4;

  // channel d opcodes
  localparam tl_opcode_t OP_ACK      = 3'd0;  // access ack, no data
  localparam tl_opcode_t OP_ACK_DATA = 3'd1;  // access ack with data

endpackage

// File: hw/tlul_reg_adapter.sv
`timescale 1ns/1ps

module tlul_reg_adapter #(
  parameter int unsigned RegAw = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // channel a, host request
  input  logic                      a_valid_i,
  input  tlul_lite_pkg::tl_opcode_t a_opcode_i,
  input  tlul_lite_pkg::tl_addr_t   a_address_i,
  input  tlul_lite_pkg::tl_data_t   a_data_i,
  input  tlul_lite_pkg::tl_mask_t   a_mask_i,
  input  tlul_lite_pkg::tl_source_t a_source_i,
  output logic                      a_ready_o,

  // channel d, response
  output logic                      d_valid_o,
  input  logic                      d_ready_i,
  output tlul_lite_pkg::tl_opcode_t d_opcode_o,
  output tlul_lite_pkg::tl_data_t   d_data_o,
  output logic                      d_error_o,
  output tlul_lite_pkg::tl_source_t d_source_o,

  // register access
  output logic                      reg_we_o,
  output logic                      reg_re_o,
  output logic [RegAw-1:0]          reg_addr_o,
  output tlul_lite_pkg::tl_data_t   reg_wdata_o,
  output logic                      reg_wmask_o,
  input  tlul_lite_pkg::tl_data_t   reg_rdata_i,
  input  logic                      reg_err_i
);

  logic a_fire;
  logic is_get;
  logic is_put;
  logic addr_oob;
  logic req_ok;

  logic                      d_valid_q;
  tlul_lite_pkg::tl_opcode_t d_opcode_q;
  tlul_lite_pkg::tl_data_t   d_data_q;
  logic                      d_error_q;
  tlul_lite_pkg::tl_source_t d_source_q;

  // --------------------------------------------------
  // request decode
  // --------------------------------------------------

  assign a_ready_o = ~d_valid_q;  // only one request in flight
  assign a_fire    = a_valid_i & a_ready_o;

  assign is_get   = (a_opcode_i == tlul_lite_pkg::OP_GET);
  assign is_put   = (a_opcode_i == tlul_lite_pkg::OP_PUT_FULL) |
                    (a_opcode_i == tlul_lite_pkg::OP_PUT_PARTIAL);
  assign addr_oob = (a_address_i >> RegAw) != '0;  // beyond the register window
  assign req_ok   = (is_get | is_put) & ~addr_oob;

  // strobes last only for the accepting cycle
  assign reg_we_o    = a_fire & is_put & ~addr_oob;
  assign reg_re_o    = a_fire & is_get & ~addr_oob;
  assign reg_addr_o  = a_address_i[RegAw-1:0];
  assign reg_wdata_o = a_data_i;
  assign reg_wmask_o = a_mask_i[0];  // registers live in byte 0

  // --------------------------------------------------
  // response
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_valid_q <= 1'b0;
    end else if (a_fire) begin
      d_valid_q <= 1'b1;
    end else if (d_ready_i) begin
      d_valid_q <= 1'b0;  // taken by the host
    end
  end

  // held until the response is taken, since a_ready_o blocks new captures
  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      d_opcode_q <= is_get ? tlul_lite_pkg::OP_ACK_DATA : tlul_lite_pkg::OP_ACK;
      d_data_q   <= is_get ? reg_rdata_i : '0;
      d_error_q  <= ~req_ok | reg_err_i;
      d_source_q <= a_source_i;  // echo requester id
    end
  end

  assign d_valid_o  = d_valid_q;
  assign d_opcode_o = d_opcode_q;
  assign d_data_o   = d_data_q;
  assign d_error_o  = d_error_q;
  assign d_source_o = d_source_q;

endmodule

// File: rlight_top.f
hw/rlight_pkg.sv
hw/tlul_lite_pkg.sv
hw/tlul_reg_adapter.sv
hw/rlight_regs.sv
hw/rlight_engine.sv
hw/rlight_top.sv
testbench/rlight_assertions.sv
testbench/tb_rlight_top.sv

// File: testbench/rlight_assertions.sv
`timescale 1ns/1ps

module rlight_assertions (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      a_ready_i,
  input logic                      d_valid_i,
  input logic                      d_ready_i,
  input tlul_lite_pkg::tl_opcode_t d_opcode_i,
  input tlul_lite_pkg::tl_data_t   d_data_i,
  input logic                      d_error_i,
  input tlul_lite_pkg::tl_source_t d_source_i,
  input rlight_pkg::led_t          led_i,
  input logic                      pat_load_i
);

  int unsigned fail_cnt = 0;  // failed assertions so far

  // --------------------------------------------------
  // bus handshake
  // --------------------------------------------------

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_i && !d_ready_i |=> d_valid_i && $stable(d_opcode_i) && $stable(d_data_i) &&
                                $stable(d_error_i) && $stable(d_source_i))
  else begin
    fail_cnt++;
    $error("d channel changed before the response was taken");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) d_valid_i |-> !a_ready_i)
  else begin
    fail_cnt++;
    $error("a_ready_o high while a response is pending");
  end

  // --------------------------------------------------
  // led stepping
  // --------------------------------------------------

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    led_i != $past(led_i) |-> $past(pat_load_i) ||
      led_i == {$past(led_i[6:0]), $past(led_i[7])} ||  // left by one
      led_i == {$past(led_i[0]), $past(led_i[7:1])})    // right by one
  else begin
    fail_cnt++;
    $error("led_o changed by more than a one-bit rotation");
  end

endmodule

bind rlight_top rlight_assertions u_assertions (
  .clk_i,
  .rst_ni,
  .a_ready_i (a_ready_o),
  .d_valid_i (d_valid_o),
  .d_ready_i,
  .d_opcode_i(d_opcode_o),
  .d_data_i  (d_data_o),
  .d_error_i (d_error_o),
  .d_source_i(d_source_o),
  .led_i     (led_o),
  .pat_load_i(pat_load)
);

// File: testbench/tb_rlight_top.sv
`timescale 1ns/1ps

module tb_rlight_top;

  localparam rlight_pkg::delay_t ResetDelay = 8'd3;
  localparam rlight_pkg::led_t   ResetLed   = 8'h33;
  localparam int unsigned        Timeout    = 400;  // cycles per wait

  logic                      clk_i;
  logic                      rst_ni;
  logic                      a_valid_i;
  tlul_lite_pkg::tl_opcode_t a_opcode_i;
  tlul_lite_pkg::tl_addr_t   a_address_i;
  tlul_lite_pkg::tl_data_t   a_data_i;
  tlul_lite_pkg::tl_mask_t   a_mask_i;
  tlul_lite_pkg::tl_source_t a_source_i;
  logic                      a_ready_o;
  logic                      d_valid_o;
  logic                      d_ready_i;
  tlul_lite_pkg::tl_opcode_t d_opcode_o;
  tlul_lite_pkg::tl_data_t   d_data_o;
  logic                      d_error_o;
  tlul_lite_pkg::tl_source_t d_source_o;
  rlight_pkg::led_t          led_o;

  int unsigned cyc = 0;  // posedges since time zero
  int unsigned accept_cyc;
  int unsigned last_step_cyc;
  int unsigned exp_step_cyc;

  // reference model state
  rlight_pkg::rl_mode_e mdl_mode;
  rlight_pkg::delay_t   mdl_delay;
  rlight_pkg::led_t     mdl_led;
  logic                 mdl_left;
  int unsigned          mdl_pp;

  tlul_lite_pkg::tl_data_t rdata;
  tlul_lite_pkg::tl_addr_t addr;
  tlul_lite_pkg::tl_addr_t addr_pool [4];

  rlight_top u_dut (.*);

  always #2 clk_i = ~clk_i;
  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------

  task automatic check_led(input string name, input rlight_pkg::led_t act,
                           input rlight_pkg::led_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, act, exp);
      stop_on_error();
    end
  endtask

  task automatic check_data(input string name, input tlul_lite_pkg::tl_data_t act,
                            input tlul_lite_pkg::tl_data_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, act, exp);
      stop_on_error();
    end
  endtask

  task automatic check_resp(input tlul_lite_pkg::tl_opcode_t op,
                            input tlul_lite_pkg::tl_opcode_t exp_op,
                            input logic err, input logic exp_err,
                            input tlul_lite_pkg::tl_source_t src,
                            input tlul_lite_pkg::tl_source_t exp_src);
    if (op !== exp_op) begin
      $display("CHECK FAILED at %0t: d_opcode_o is %0d, expected %0d", $time, op, exp_op);
      stop_on_error();
    end
    if (err !== exp_err) begin
      $display("CHECK FAILED at %0t: d_error_o is %b, expected %b", $time, err, exp_err);
      stop_on_error();
    end
    if (src !== exp_src) begin
      $display("CHECK FAILED at %0t: d_source_o is %h, expected %h", $time, src, exp_src);
      stop_on_error();
    end
  endtask

  task automatic check_interval(input rlight_pkg::delay_t dly, input int unsigned cycles);
    if (cycles != int'(dly) + 1) begin
      $display("CHECK FAILED at %0t: led_o step interval is %0d, expected %0d",
               $time, cycles, int'(dly) + 1);
      stop_on_error();
    end
  endtask

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  function automatic rlight_pkg::led_t rot_by_one(input rlight_pkg::led_t v, input logic left);
    if (left) begin
      return rlight_pkg::led_t'((v << 1) | (v >> 7));
    end
    return rlight_pkg::led_t'((v >> 1) | (v << 7));
  endfunction

  function automatic rlight_pkg::led_t model_step();
    case (mdl_mode)
      rlight_pkg::MODE_ROT_LEFT:  mdl_led = rot_by_one(mdl_led, 1'b1);
      rlight_pkg::MODE_ROT_RIGHT: mdl_led = rot_by_one(mdl_led, 1'b0);
      rlight_pkg::MODE_PING_PONG: begin
        mdl_led = rot_by_one(mdl_led, mdl_left);
        mdl_pp++;
        if (mdl_pp == rlight_pkg::PP_STEPS) begin  // turn around
          mdl_pp   = 0;
          mdl_left = !mdl_left;
        end
      end
      default: ;
    endcase
    return mdl_led;
  endfunction

  function automatic logic is_unmapped(input tlul_lite_pkg::tl_addr_t a);
    return !(a inside {rlight_pkg::REG_MODE, rlight_pkg::REG_PATTERN, rlight_pkg::REG_DELAY});
  endfunction

  function automatic tlul_lite_pkg::tl_data_t expected_readback(input tlul_lite_pkg::tl_addr_t a);
    if (a == rlight_pkg::REG_MODE) return 32'(mdl_mode);
    if (a == rlight_pkg::REG_DELAY) return 32'(mdl_delay);
    if (a == rlight_pkg::REG_PATTERN) return 32'(mdl_led);
    return '0;  // unmapped
  endfunction

  function automatic rlight_pkg::led_t random_pattern();
    rlight_pkg::led_t pat;
    do begin
      pat = rlight_pkg::led_t'($urandom);
    end while (pat == 8'h00 || pat == 8'hFF);  // these never move
    return pat;
  endfunction

  // --------------------------------------------------
  // bus tasks
  // --------------------------------------------------

  task automatic bus_access(input tlul_lite_pkg::tl_opcode_t op,
                            input tlul_lite_pkg::tl_addr_t a,
                            input tlul_lite_pkg::tl_data_t wdata,
                            input tlul_lite_pkg::tl_mask_t mask, input logic stall,
                            input logic exp_err, output tlul_lite_pkg::tl_data_t rsp_data);
    tlul_lite_pkg::tl_source_t src;
    int unsigned waited;
    src = tlul_lite_pkg::tl_source_t'($urandom);
    @(negedge clk_i);
    a_valid_i   = 1'b1;
    a_opcode_i  = op;
    a_address_i = a;
    a_data_i    = wdata;
    a_mask_i    = mask;
    a_source_i  = src;
    waited = 0;
    while (!a_ready_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) begin
        $display("request was never accepted, time %0t", $time);
        stop_on_error();
      end
    end
    @(negedge clk_i);  // accepted at the edge just passed
    accept_cyc = cyc;
    a_valid_i  = 1'b0;
    if (!d_valid_o) begin
      $display("no response one cycle after the request was accepted, time %0t", $time);
      stop_on_error();
    end
    d_ready_i = stall ? ($urandom_range(3) == 0) : 1'b1;
    waited = 0;
    while (!d_ready_i) begin
      @(negedge clk_i);
      waited++;
      if (!d_valid_o || waited > Timeout) begin
        $display("response was dropped or never taken, time %0t", $time);
        stop_on_error();
      end
      d_ready_i = ($urandom_range(3) == 0);  // random back-pressure
    end
    check_resp(d_opcode_o,
               (op == tlul_lite_pkg::OP_GET) ? tlul_lite_pkg::OP_ACK_DATA : tlul_lite_pkg::OP_ACK,
               d_error_o, exp_err, d_source_o, src);
    rsp_data = d_data_o;
    @(negedge clk_i);
    d_ready_i = 1'b0;
    if (d_valid_o) begin
      $display("a second response came for one request, time %0t", $time);
      stop_on_error();
    end
  endtask

  task automatic put_reg(input tlul_lite_pkg::tl_addr_t a, input tlul_lite_pkg::tl_data_t data,
                         input tlul_lite_pkg::tl_mask_t mask, input logic stall);
    tlul_lite_pkg::tl_data_t rsp;
    bus_access((mask == 4'hF) ? tlul_lite_pkg::OP_PUT_FULL : tlul_lite_pkg::OP_PUT_PARTIAL,
               a, data, mask, stall, is_unmapped(a), rsp);
    if (mask[0] && a == rlight_pkg::REG_MODE) mdl_mode = rlight_pkg::rl_mode_e'(data[1:0]);
    if (mask[0] && a == rlight_pkg::REG_DELAY) mdl_delay = data[7:0];
  endtask

  task automatic get_reg(input tlul_lite_pkg::tl_addr_t a, input logic stall,
                         output tlul_lite_pkg::tl_data_t data);
    bus_access(tlul_lite_pkg::OP_GET, a, '0, 4'hF, stall, is_unmapped(a), data);
  endtask

  task automatic load_pattern(input rlight_pkg::led_t pat);
    put_reg(rlight_pkg::REG_PATTERN, 32'(pat), 4'hF, 1'b0);  // no stall, steps may be close
    mdl_led       = pat;
    mdl_left      = 1'b1;
    mdl_pp        = 0;
    last_step_cyc = accept_cyc;
  endtask

  task automatic wait_change();
    int unsigned waited;
    waited = 0;
    while (led_o === mdl_led) begin  // model holds the last pattern seen
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) begin
        $display("led_o stopped stepping, time %0t", $time);
        stop_on_error();
      end
    end
  endtask

  task automatic run_steps(input int unsigned n);
    repeat (n) begin
      wait_change();
      check_led("led_o", led_o, model_step());
      check_interval(mdl_delay, cyc - last_step_cyc);
      last_step_cyc = cyc;
    end
  endtask

  task automatic set_up_moving(input rlight_pkg::rl_mode_e mode, input int unsigned max_dly);
    put_reg(rlight_pkg::REG_DELAY, 32'($urandom_range(max_dly, 2)), 4'hF, 1'b1);
    put_reg(rlight_pkg::REG_MODE, 32'(mode), 4'hF, 1'b1);
    load_pattern(random_pattern());
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(32'h0f7e_9fae));
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = '0;
    a_address_i = '0;
    a_data_i    = '0;
    a_mask_i    = '0;
    a_source_i  = '0;
    d_ready_i   = 1'b0;
    mdl_mode    = rlight_pkg::MODE_PING_PONG;
    mdl_delay   = ResetDelay;
    mdl_led     = ResetLed;
    mdl_left    = 1'b1;
    mdl_pp      = 0;
    addr_pool   = '{rlight_pkg::REG_MODE, rlight_pkg::REG_DELAY, 32'hC, 32'h24};
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // reset values
    if (d_valid_o || !a_ready_o) begin
      $display("bus handshake is not idle after reset");
      stop_on_error();
    end
    check_led("led_o", led_o, ResetLed);
    get_reg(rlight_pkg::REG_MODE, 1'b0, rdata);
    check_data("d_data_o", rdata, '0);
    get_reg(rlight_pkg::REG_DELAY, 1'b0, rdata);
    check_data("d_data_o", rdata, 32'(ResetDelay));

    // register access under back-pressure, mapped and unmapped
    repeat (40) begin
      addr = addr_pool[$urandom_range(3)];
      put_reg(addr, $urandom, tlul_lite_pkg::tl_mask_t'($urandom), 1'b1);
      get_reg(addr, 1'b1, rdata);
      check_data("d_data_o", rdata, expected_readback(addr));
    end
    bus_access(3'd2, rlight_pkg::REG_MODE, 32'h3, 4'hF, 1'b1, 1'b1, rdata);  // illegal opcode
    get_reg(rlight_pkg::REG_MODE, 1'b1, rdata);
    check_data("d_data_o", rdata, expected_readback(rlight_pkg::REG_MODE));

    // rotation modes
    set_up_moving(rlight_pkg::MODE_ROT_LEFT, 9);
    run_steps(12);
    set_up_moving(rlight_pkg::MODE_ROT_RIGHT, 9);
    run_steps(12);

    // ping-pong over several turnarounds
    set_up_moving(rlight_pkg::MODE_PING_PONG, 4);
    run_steps(32);

    // stop mode, readback, then back to moving
    set_up_moving(rlight_pkg::MODE_STOP, 6);
    repeat ($urandom_range(5, 2) * (int'(mdl_delay) + 1) + 2) begin
      @(negedge clk_i);
      check_led("led_o", led_o, mdl_led);
    end
    get_reg(rlight_pkg::REG_PATTERN, 1'b1, rdata);
    check_data("d_data_o", rdata, expected_readback(rlight_pkg::REG_PATTERN));
    put_reg(rlight_pkg::REG_MODE, 32'(rlight_pkg::MODE_ROT_LEFT), 4'hF, 1'b0);
    // first grid edge after the one that took the mode write
    exp_step_cyc = last_step_cyc +
                   ((accept_cyc - last_step_cyc) / (int'(mdl_delay) + 1) + 1) *
                   (int'(mdl_delay) + 1);
    wait_change();
    check_led("led_o", led_o, model_step());
    if (cyc != exp_step_cyc) begin
      $display("CHECK FAILED at %0t: led_o step cycle is %0d, expected %0d",
               $time, cyc, exp_step_cyc);
      stop_on_error();
    end
    last_step_cyc = cyc;
    run_steps(4);

    if (u_dut.u_assertions.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
